//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = hilbertTb
FILELIST = sim.f
BUILD_DIR = obj_dir
PASS_TEXT = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- common/hilbertCoeffPkg.sv
// Coefficient widths, tap count, centre index and the constant Hilbert coefficient table.

package hilbertCoeffPkg;

	// Each coefficient is a signed 18-bit integer scaled by 100000.
	localparam int COEFF_WIDTH = 18;

	// The filter has 27 taps.
	localparam int TAP_COUNT = 27;

	// The centre tap sets the group delay and the in-phase delay.
	localparam int CENTER_TAP = (TAP_COUNT - 1) / 2;

	typedef logic signed [COEFF_WIDTH-1:0] coeffT;

	// Antisymmetric Hilbert table. Odd taps, including the centre, are zero.
	// The first half is negative and the second half mirrors it with the sign flipped.
	localparam coeffT COEFF_TABLE [TAP_COUNT] = '{
		-18'sd775, 18'sd0,
		-18'sd1582, 18'sd0,
		-18'sd3114, 18'sd0,
		-18'sd5642, 18'sd0,
		-18'sd10043, 18'sd0,
		-18'sd19511, 18'sd0,
		-18'sd63075, 18'sd0,
		18'sd63075, 18'sd0,
		18'sd19511, 18'sd0,
		18'sd10043, 18'sd0,
		18'sd5642, 18'sd0,
		18'sd3114, 18'sd0,
		18'sd1582, 18'sd0,
		18'sd775
	};

endpackage

//--- common/hilbertDataPkg.sv
// Sample, FIR-result and analytic-output structs with the data path widths.

package hilbertDataPkg;

	// Width of an input sample and of each analytic output component.
	localparam int SAMPLE_WIDTH = 16;

	// Width of the FIR sum.
	// 27 products of 34 bits each cannot overflow 40 bits.
	localparam int ACC_WIDTH = 40;

	// One input sample with its strobe.
	typedef struct packed {
		logic valid;
		logic signed [SAMPLE_WIDTH-1:0] data;
	} sampleT;

	// Full-precision FIR sum together with the centre-tap sample that
	// becomes the in-phase value.
	typedef struct packed {
		logic valid;
		logic signed [ACC_WIDTH-1:0] sum;
		logic signed [SAMPLE_WIDTH-1:0] center;
	} firResultT;

	// Analytic pair at sample width, plus a flag raised when the
	// quadrature value had to be clamped.
	typedef struct packed {
		logic valid;
		logic signed [SAMPLE_WIDTH-1:0] inPhase;
		logic signed [SAMPLE_WIDTH-1:0] quadrature;
		logic saturated;
	} analyticT;

endpackage

//--- hilbertFir/firCore.sv
// Pipelined 27-tap FIR core with sample delay line, registered products and registered sum.

`timescale 1ns/1ps

module firCore import hilbertCoeffPkg::*, hilbertDataPkg::*; (
	input logic clock,
	input logic rstN,
	input sampleT sampleIn,
	input coeffT taps [TAP_COUNT],
	input logic tapsReady,
	output firResultT firResult
);

	// A full product of one sample and one coefficient.
	localparam int PROD_WIDTH = SAMPLE_WIDTH + COEFF_WIDTH;

	// Samples are only taken once every tap holds a loaded coefficient.
	logic accept;

	// Delay line, entry 0 is the newest accepted sample.
	logic signed [SAMPLE_WIDTH-1:0] sampleLine [TAP_COUNT];
	logic lineValid;

	// Product stage.
	logic signed [PROD_WIDTH-1:0] products [TAP_COUNT];
	logic signed [SAMPLE_WIDTH-1:0] prodCenter;
	logic prodValid;

	// Adder tree output feeding the sum register.
	logic signed [ACC_WIDTH-1:0] productSum;

	assign accept = sampleIn.valid && tapsReady;

	// The line shifts only on accepted samples.
	// It starts cleared so the centre tap reads zero until 13 samples have passed.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			lineValid <= 1'b0;
			for (int i = 0; i < TAP_COUNT; i++) begin
				sampleLine[i] <= '0;
			end
		end else begin
			lineValid <= accept;
			if (accept) begin
				sampleLine[0] <= sampleIn.data;
				for (int i = 1; i < TAP_COUNT; i++) begin
					sampleLine[i] <= sampleLine[i-1];
				end
			end
		end
	end

	// First pipeline stage: one multiplier per tap.
	// The centre sample is captured here so it stays aligned with its sum.
	always_ff @(posedge clock) begin
		if (lineValid) begin
			for (int i = 0; i < TAP_COUNT; i++) begin
				products[i] <= sampleLine[i] * taps[i];
			end
			prodCenter <= sampleLine[CENTER_TAP];
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			prodValid <= 1'b0;
		end else begin
			prodValid <= lineValid;
		end
	end

	// Products are sign-extended into the wide sum.
	always_comb begin
		productSum = '0;
		for (int i = 0; i < TAP_COUNT; i++) begin
			productSum = productSum + products[i];
		end
	end

	// Second pipeline stage: the registered sum with its centre sample.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			firResult <= '0;
		end else begin
			firResult.valid <= prodValid;
			if (prodValid) begin
				firResult.sum <= productSum;
				firResult.center <= prodCenter;
			end
		end
	end

endmodule

//--- hilbertFir/tapStore.sv
// Tap store that shifts the coefficient stream into tap registers and tracks filter readiness.

`timescale 1ns/1ps

module tapStore import hilbertCoeffPkg::*; (
	input logic clock,
	input logic rstN,
	input coeffT coeffOut,
	input logic coeffStrobe,
	input logic coeffSetFlag,
	output coeffT taps [TAP_COUNT],
	output logic tapsReady
);

	// Coefficients enter at the top of the chain and move down by one tap
	// per strobe. After 27 strobes the first coefficient sits in tap 0.
	// The chain holds between strobes.
	always_ff @(posedge clock) begin
		if (coeffStrobe) begin
			for (int i = 0; i < TAP_COUNT - 1; i++) begin
				taps[i] <= taps[i+1];
			end
			taps[TAP_COUNT-1] <= coeffOut;
		end
	end

	// Ready rises one cycle after the loader's set flag.
	// The set flag arrives together with the last strobe, so it must win.
	// Any other strobe means a reload has begun and the taps are no longer whole.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			tapsReady <= 1'b0;
		end else if (coeffSetFlag) begin
			tapsReady <= 1'b1;
		end else if (coeffStrobe) begin
			tapsReady <= 1'b0;
		end
	end

endmodule

//--- hw/analyticOutput.sv
// Output stage with rounding shift, saturation to sample width and the analytic output register.

`timescale 1ns/1ps

module analyticOutput import hilbertDataPkg::*; #(
	parameter int OUT_SHIFT = 17
) (
	input logic clock,
	input logic rstN,
	input firResultT firResult,
	output analyticT analyticOut
);

	// Half of one output step, added before the shift so it rounds to nearest.
	localparam logic signed [ACC_WIDTH-1:0] ROUND_BIAS =
		(OUT_SHIFT > 0) ? (ACC_WIDTH'(1) <<< (OUT_SHIFT - 1)) : '0;

	// Limits of a signed sample, held at sum width for comparison.
	localparam logic signed [ACC_WIDTH-1:0] SAT_MAX = (2 ** (SAMPLE_WIDTH - 1)) - 1;
	localparam logic signed [ACC_WIDTH-1:0] SAT_MIN = -(2 ** (SAMPLE_WIDTH - 1));

	logic signed [ACC_WIDTH-1:0] roundedSum;
	logic signed [ACC_WIDTH-1:0] shiftedSum;
	logic signed [SAMPLE_WIDTH-1:0] quadNext;
	logic satNext;

	// Round, shift arithmetically, then clamp.
	// The bias cannot overflow the sum because the FIR gain stays far below 40 bits.
	always_comb begin
		roundedSum = firResult.sum + ROUND_BIAS;
		shiftedSum = roundedSum >>> OUT_SHIFT;
		if (shiftedSum > SAT_MAX) begin
			quadNext = SAT_MAX[SAMPLE_WIDTH-1:0];
			satNext = 1'b1;
		end else if (shiftedSum < SAT_MIN) begin
			quadNext = SAT_MIN[SAMPLE_WIDTH-1:0];
			satNext = 1'b1;
		end else begin
			quadNext = shiftedSum[SAMPLE_WIDTH-1:0];
			satNext = 1'b0;
		end
	end

	// The pair leaves together with its valid, one cycle after the FIR result.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			analyticOut <= '0;
		end else begin
			analyticOut.valid <= firResult.valid;
			analyticOut.inPhase <= firResult.center;
			analyticOut.quadrature <= quadNext;
			analyticOut.saturated <= satNext;
		end
	end

endmodule

//--- hw/coeffLoader.sv
// Coefficient loader that streams the Hilbert tap table while enabled and flags the last tap.

`timescale 1ns/1ps

module coeffLoader import hilbertCoeffPkg::*; (
	input logic clock,
	input logic rstN,
	input logic loadEnable,
	output coeffT coeffOut,
	output logic coeffStrobe,
	output logic coeffSetFlag
);

	// The index only has to reach TAP_COUNT - 1.
	localparam int INDEX_WIDTH = $clog2(TAP_COUNT);
	localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(TAP_COUNT - 1);

	// Position of the next coefficient to send.
	logic [INDEX_WIDTH-1:0] coeffIndex;

	// One coefficient leaves per clock while loadEnable is high.
	// The first one appears one cycle after the enable rises.
	// The last one carries coeffSetFlag, after which the index holds and
	// no further strobes are issued until the enable is dropped.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			coeffIndex <= '0;
			coeffOut <= '0;
			coeffStrobe <= 1'b0;
			coeffSetFlag <= 1'b0;
		end else if (!loadEnable) begin
			// Dropping the enable abandons any load in progress.
			// The next load starts again from index 0.
			coeffIndex <= '0;
			coeffOut <= '0;
			coeffStrobe <= 1'b0;
			coeffSetFlag <= 1'b0;
		end else if (!coeffSetFlag) begin
			coeffOut <= COEFF_TABLE[coeffIndex];
			coeffStrobe <= 1'b1;
			if (coeffIndex == LAST_INDEX) begin
				// The whole table has gone out with this coefficient.
				coeffSetFlag <= 1'b1;
			end else begin
				coeffIndex <= coeffIndex + 1'b1;
			end
		end else begin
			// Table finished. Hold the flag and the last value, strobe stays quiet.
			coeffStrobe <= 1'b0;
		end
	end

endmodule

//--- hw/hilbertTop.sv
// Hilbert transform top level joining coefficient loader, tap store, FIR core and output stage.

`timescale 1ns/1ps

module hilbertTop import hilbertCoeffPkg::*, hilbertDataPkg::*; #(
	parameter int OUT_SHIFT = 17
) (
	input logic clock,
	input logic rstN,
	input logic loadEnable,
	input sampleT sampleIn,
	output logic filterReady,
	output analyticT analyticOut
);

	// Coefficient stream from loader to tap store.
	coeffT coeffOut;
	logic coeffStrobe;
	logic coeffSetFlag;

	// Loaded taps and their ready level.
	coeffT taps [TAP_COUNT];
	logic tapsReady;

	// Full-precision result between FIR core and output stage.
	firResultT firResult;

	// The outside sees the tap store's ready level directly.
	assign filterReady = tapsReady;

	coeffLoader coeffLoader_inst (
		.clock(clock),
		.rstN(rstN),
		.loadEnable(loadEnable),
		.coeffOut(coeffOut),
		.coeffStrobe(coeffStrobe),
		.coeffSetFlag(coeffSetFlag)
	);

	tapStore tapStore_inst (
		.clock(clock),
		.rstN(rstN),
		.coeffOut(coeffOut),
		.coeffStrobe(coeffStrobe),
		.coeffSetFlag(coeffSetFlag),
		.taps(taps),
		.tapsReady(tapsReady)
	);

	firCore firCore_inst (
		.clock(clock),
		.rstN(rstN),
		.sampleIn(sampleIn),
		.taps(taps),
		.tapsReady(tapsReady),
		.firResult(firResult)
	);

	analyticOutput #(
		.OUT_SHIFT(OUT_SHIFT)
	) analyticOutput_inst (
		.clock(clock),
		.rstN(rstN),
		.firResult(firResult),
		.analyticOut(analyticOut)
	);

endmodule

//--- sim.f
common/hilbertCoeffPkg.sv
common/hilbertDataPkg.sv
hw/coeffLoader.sv
hilbertFir/tapStore.sv
hilbertFir/firCore.sv
hw/analyticOutput.sv
hw/hilbertTop.sv
tb/hilbertTop_chk.sv
tb/hilbertTb.sv

//--- tb/hilbertTb.sv
// Testbench for the Hilbert top level with reference model, stimulus, output monitor and watchdog.

`timescale 1ns/1ps

module hilbertTb import hilbertCoeffPkg::*, hilbertDataPkg::*; ();

	localparam int CLOCK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int OUT_SHIFT = 17;
	// filterReady follows the rising load enable by this many cycles.
	localparam int LOAD_CYCLES = 28;
	localparam int LOAD_LIMIT = 64;
	localparam int DROP_COUNT = 10;
	localparam int LAST_DROP = 20;
	localparam int IMPULSE_COUNT = 31;
	localparam int RANDOM_COUNT = 200;
	localparam int SAT_BLOCK = 14;
	localparam int SAT_COUNT = 4 * SAT_BLOCK;
	// Random gaps can at most double the random stream, and two loads are run.
	localparam int PLANNED_CYCLES = RESET_CYCLES + DROP_COUNT + 2 * LOAD_LIMIT
		+ IMPULSE_COUNT + 2 * RANDOM_COUNT + SAT_COUNT + 16;
	localparam int WATCHDOG_NS = 2 * PLANNED_CYCLES * CLOCK_PERIOD;
	localparam logic signed [SAMPLE_WIDTH-1:0] SAT_HIGH = {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};
	localparam logic signed [SAMPLE_WIDTH-1:0] SAT_LOW = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};
	localparam longint SAT_MAX = longint'(SAT_HIGH);
	localparam longint SAT_MIN = longint'(SAT_LOW);

	logic clock;
	logic rstN;
	logic loadEnable;
	sampleT sampleIn;
	logic filterReady;
	analyticT analyticOut;

	// Accepted samples, entry 0 newest, as the FIR delay line should hold them.
	logic signed [SAMPLE_WIDTH-1:0] history [TAP_COUNT];
	analyticT expected [$];
	int satSeen;

	hilbertTop #(
		.OUT_SHIFT(OUT_SHIFT)
	) hilbertTop_inst (
		.clock(clock),
		.rstN(rstN),
		.loadEnable(loadEnable),
		.sampleIn(sampleIn),
		.filterReady(filterReady),
		.analyticOut(analyticOut)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "Simulation stopped on a failed check");
	endtask

	// Direct convolution with the table, then round, shift and clamp.
	function automatic analyticT modelOutput();
		longint acc;
		longint scaled;
		analyticT result;
		acc = 0;
		for (int i = 0; i < TAP_COUNT; i++) begin
			acc += longint'(history[i]) * longint'(COEFF_TABLE[i]);
		end
		scaled = (acc + (64'sd1 <<< (OUT_SHIFT - 1))) >>> OUT_SHIFT;
		result.valid = 1'b1;
		result.inPhase = history[CENTER_TAP];
		result.saturated = (scaled > SAT_MAX) || (scaled < SAT_MIN);
		if (scaled > SAT_MAX) begin
			scaled = SAT_MAX;
		end else if (scaled < SAT_MIN) begin
			scaled = SAT_MIN;
		end
		result.quadrature = SAMPLE_WIDTH'(scaled);
		return result;
	endfunction

	// A counted sample is one the DUT must accept, so the model takes it too.
	task automatic driveSample(input logic valid, input logic signed [SAMPLE_WIDTH-1:0] data,
		input logic counted);
		@(negedge clock);
		sampleIn.valid = valid;
		sampleIn.data = data;
		if (counted) begin
			for (int i = TAP_COUNT - 1; i > 0; i--) begin
				history[i] = history[i-1];
			end
			history[0] = data;
			expected.push_back(modelOutput());
		end
	endtask

	// Raise loadEnable and count cycles until filterReady.
	// From cycle 2 the old ready level is gone, so the samples sent then are dropped.
	task automatic runLoad(input int lastDrop);
		int cycles;
		logic done;
		cycles = 0;
		done = 1'b0;
		@(negedge clock);
		loadEnable = 1'b1;
		sampleIn = '0;
		while (!done) begin
			@(negedge clock);
			cycles++;
			done = (cycles >= 2 && filterReady) || cycles >= LOAD_LIMIT;
			sampleIn.valid = !done && cycles >= 2 && cycles <= lastDrop;
			sampleIn.data = SAMPLE_WIDTH'($urandom);
		end
		assert (cycles == LOAD_CYCLES) else stopWithFailure($sformatf(
			"[FAIL] %0d ns: filterReady after %0d cycles, expected %0d",
			$time, cycles, LOAD_CYCLES));
	endtask

	task automatic checkOutput();
		analyticT want;
		if (expected.size() == 0) begin
			stopWithFailure($sformatf("[FAIL] %0d ns: output valid without an accepted sample",
				$time));
		end else begin
			want = expected.pop_front();
			if (want.saturated) begin
				satSeen++;
			end
			assert (analyticOut === want) else stopWithFailure($sformatf(
				"[FAIL] %0d ns: got I=%0d Q=%0d sat=%0b, expected I=%0d Q=%0d sat=%0b",
				$time, analyticOut.inPhase, analyticOut.quadrature, analyticOut.saturated,
				want.inPhase, want.quadrature, want.saturated));
		end
	endtask

	// Outputs are stable at the falling edge.
	always @(negedge clock) begin
		if (rstN && analyticOut.valid) begin
			checkOutput();
		end
	end

	initial begin
		#(WATCHDOG_NS);
		stopWithFailure("Watchdog timeout: the test did not finish in the expected time");
	end

	initial begin
		void'($urandom(32'h5f54));
		clock = 1'b0;
		rstN = 1'b0;
		loadEnable = 1'b0;
		sampleIn = '0;
		satSeen = 0;
		for (int i = 0; i < TAP_COUNT; i++) begin
			history[i] = '0;
		end
		repeat (RESET_CYCLES) @(negedge clock);
		assert (!filterReady && !analyticOut.valid) else stopWithFailure($sformatf(
			"[FAIL] %0d ns: filterReady or output valid high in reset", $time));
		rstN = 1'b1;
		// Nothing is loaded yet, so every sample here is dropped.
		repeat (DROP_COUNT) driveSample(1'b1, SAMPLE_WIDTH'($urandom), 1'b0);
		runLoad(LAST_DROP);
		// The impulse response walks out the coefficient table in index order.
		driveSample(1'b1, 16'sd16384, 1'b1);
		repeat (IMPULSE_COUNT - 1) driveSample(1'b1, '0, 1'b1);
		for (int n = 0; n < RANDOM_COUNT; n++) begin
			if ($urandom_range(3) == 0) begin
				driveSample(1'b0, '0, 1'b0);
			end
			driveSample(1'b1, SAMPLE_WIDTH'($urandom), 1'b1);
		end
		// Reload; the delay line keeps its contents through it.
		@(negedge clock);
		loadEnable = 1'b0;
		sampleIn = '0;
		runLoad(LAST_DROP);
		// Full-scale blocks about half the filter long push the sum past both limits.
		for (int n = 0; n < SAT_COUNT; n++) begin
			driveSample(1'b1, ((n / SAT_BLOCK) % 2 == 0) ? SAT_HIGH : SAT_LOW, 1'b1);
		end
		driveSample(1'b0, '0, 1'b0);
		while (expected.size() != 0) begin
			@(negedge clock);
		end
		if (satSeen > 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			stopWithFailure($sformatf(
				"[FAIL] %0d ns: no saturated output was produced", $time));
		end
	end

endmodule

//--- tb/hilbertTop_chk.sv
// Bound checker with reset, output latency and saturation assertions for the Hilbert top level.

`timescale 1ns/1ps

module hilbertTop_chk import hilbertDataPkg::*; (
	input logic clock,
	input logic rstN,
	input sampleT sampleIn,
	input logic filterReady,
	input analyticT analyticOut
);

	localparam logic signed [SAMPLE_WIDTH-1:0] QUAD_MAX = {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};
	localparam logic signed [SAMPLE_WIDTH-1:0] QUAD_MIN = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};

	// The output register updates three edges after the accepting edge.
	// Its sampled value therefore trails the sampled accept by four.
	localparam int SAMPLED_DELAY = 4;

	logic accept;

	// filterReady is the tap store's ready level, the same one the FIR core uses.
	assign accept = sampleIn.valid && filterReady;

	// While reset is held nothing may claim to be ready or valid.
	resetQuiet: assert property (@(posedge clock)
		!rstN |-> (!filterReady && !analyticOut.valid))
		else $error("filterReady or output valid high during reset");

	// Every output needs a sample accepted exactly three cycles before.
	validNeedsSample: assert property (@(posedge clock) disable iff (!rstN)
		analyticOut.valid |-> $past(accept, SAMPLED_DELAY))
		else $error("output valid without an accepted sample three cycles earlier");

	// And every accepted sample yields its output on time.
	sampleGivesValid: assert property (@(posedge clock) disable iff (!rstN)
		$past(accept, SAMPLED_DELAY) |-> analyticOut.valid)
		else $error("accepted sample produced no output three cycles later");

	// A clamped quadrature sits on one of the two range limits.
	saturationAtLimit: assert property (@(posedge clock) disable iff (!rstN)
		(analyticOut.valid && analyticOut.saturated)
			|-> (analyticOut.quadrature == QUAD_MAX || analyticOut.quadrature == QUAD_MIN))
		else $error("saturated flag set with quadrature inside the range");

endmodule

bind hilbertTop hilbertTop_chk hilbertTop_chk_inst (
	.clock(clock),
	.rstN(rstN),
	.sampleIn(sampleIn),
	.filterReady(filterReady),
	.analyticOut(analyticOut)
);
